/* logic/mipsPkg.sv */
package mipsPkg;

    // Widths fixed by the ISA
    typedef logic [31:0] word_t;
    typedef logic [4:0]  regIdx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [15:0] imm_t;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluSll,
        aluLui
    } aluOp_t;

    // Destination register choice in E
    typedef enum logic [1:0] {
        dstRd,
        dstRt,
        dstRa
    } regDst_t;

    // Link register written by jal
    localparam regIdx_t regRa = 5'd31;

    // Primary opcodes
    localparam opcode_t opSpecial = 6'b000000;
    localparam opcode_t opJ       = 6'b000010;
    localparam opcode_t opJal     = 6'b000011;
    localparam opcode_t opBeq     = 6'b000100;
    localparam opcode_t opBne     = 6'b000101;
    localparam opcode_t opAddiu   = 6'b001001;
    localparam opcode_t opAndi    = 6'b001100;
    localparam opcode_t opOri     = 6'b001101;
    localparam opcode_t opLui     = 6'b001111;
    localparam opcode_t opLw      = 6'b100011;
    localparam opcode_t opSw      = 6'b101011;

    // Function codes under opSpecial
    localparam funct_t fnSll  = 6'b000000;
    localparam funct_t fnAddu = 6'b100001;
    localparam funct_t fnSubu = 6'b100011;
    localparam funct_t fnAnd  = 6'b100100;
    localparam funct_t fnOr   = 6'b100101;
    localparam funct_t fnSlt  = 6'b101010;

endpackage

/* logic/pcUnit.sv */
`timescale 1ns/1ns

module pcUnit #(
    parameter mipsPkg::word_t resetPc = '0
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           branchTaken,
    input  mipsPkg::word_t branchTarget,
    input  logic           isJump,
    input  mipsPkg::word_t jumpTarget,
    output mipsPkg::word_t pcF,
    output logic           instEn
);
    import mipsPkg::*;

    word_t pcPlus4;
    word_t nextPc;

    assign pcPlus4 = pcF + 32'd4;

    // Jump wins over branch, branch over sequential
    always_comb begin
        if (isJump) begin
            nextPc = jumpTarget;
        end else if (branchTaken) begin
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    // PC holds until fetch is enabled, so resetPc is fetched first
    always_ff @(posedge clk) begin
        if (reset) begin
            pcF    <= resetPc;
            instEn <= 1'b0;
        end else begin
            instEn <= 1'b1;
            if (instEn) begin
                pcF <= nextPc;
            end
        end
    end

    pcAligned: assert property (@(posedge clk) disable iff (reset) instEn |-> pcF[1:0] == 2'b00)
        else $error("PC not word aligned: %h", pcF);

endmodule

/* logic/controlDecoder.sv */
`timescale 1ns/1ns

module controlDecoder (
    input  logic             clk,
    input  logic             reset,
    input  mipsPkg::word_t   instr,
    output logic             signExt,
    output logic             isBranch,
    output logic             branchNe,
    output logic             isJump,
    output logic             isLink,
    output mipsPkg::regDst_t regDstE,
    output logic             aluSrcE,
    output mipsPkg::aluOp_t  aluOpE,
    output logic             memReadM,
    output logic             memWriteM,
    output logic             regWriteW,
    output logic             memToRegW
);
    import mipsPkg::*;

    opcode_t    opcode;
    funct_t     funct;
    logic [1:0] startup;
    logic       validD;
    logic       branchD;
    logic       jumpD;
    logic       linkD;
    regDst_t    regDstD;
    logic       aluSrcD;
    aluOp_t     aluOpD;
    logic       memReadD;
    logic       memWriteD;
    logic       regWriteD;
    logic       memToRegD;
    logic       memReadE;
    logic       memWriteE;
    logic       regWriteE;
    logic       memToRegE;
    logic       regWriteM;
    logic       memToRegM;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    // Main and ALU decode in one place; anything unknown is a nop
    always_comb begin
        signExt   = 1'b0;
        branchD   = 1'b0;
        branchNe  = 1'b0;
        jumpD     = 1'b0;
        linkD     = 1'b0;
        regDstD   = dstRt;
        aluSrcD   = 1'b1;
        aluOpD    = aluAdd;
        memReadD  = 1'b0;
        memWriteD = 1'b0;
        regWriteD = 1'b0;
        memToRegD = 1'b0;
        case (opcode)
            opSpecial: begin
                regDstD   = dstRd;
                aluSrcD   = 1'b0;
                regWriteD = 1'b1;
                case (funct)
                    fnAddu:  aluOpD = aluAdd;
                    fnSubu:  aluOpD = aluSub;
                    fnAnd:   aluOpD = aluAnd;
                    fnOr:    aluOpD = aluOr;
                    fnSlt:   aluOpD = aluSlt;
                    fnSll:   aluOpD = aluSll;
                    default: regWriteD = 1'b0;
                endcase
            end
            opAddiu: begin
                signExt   = 1'b1;
                regWriteD = 1'b1;
            end
            opAndi: begin
                aluOpD    = aluAnd;
                regWriteD = 1'b1;
            end
            opOri: begin
                aluOpD    = aluOr;
                regWriteD = 1'b1;
            end
            opLui: begin
                aluOpD    = aluLui;
                regWriteD = 1'b1;
            end
            opLw: begin
                signExt   = 1'b1;
                memReadD  = 1'b1;
                memToRegD = 1'b1;
                regWriteD = 1'b1;
            end
            opSw: begin
                signExt   = 1'b1;
                memWriteD = 1'b1;
            end
            opBeq: begin
                signExt = 1'b1;
                branchD = 1'b1;
            end
            opBne: begin
                signExt  = 1'b1;
                branchD  = 1'b1;
                branchNe = 1'b1;
            end
            opJ: jumpD = 1'b1;
            opJal: begin
                jumpD     = 1'b1;
                linkD     = 1'b1;
                regDstD   = dstRa;
                aluSrcD   = 1'b0;
                regWriteD = 1'b1;
            end
            default: ;
        endcase
    end

    // D holds a fetched word two cycles after reset releases
    assign validD   = startup[1];
    assign isBranch = validD & branchD;
    assign isJump   = validD & jumpD;
    assign isLink   = validD & linkD;

    always_ff @(posedge clk) begin
        if (reset) begin
            startup   <= 2'b00;
            regDstE   <= dstRd;
            aluSrcE   <= 1'b0;
            aluOpE    <= aluAdd;
            memReadE  <= 1'b0;
            memWriteE <= 1'b0;
            regWriteE <= 1'b0;
            memToRegE <= 1'b0;
            memReadM  <= 1'b0;
            memWriteM <= 1'b0;
            regWriteM <= 1'b0;
            memToRegM <= 1'b0;
            regWriteW <= 1'b0;
            memToRegW <= 1'b0;
        end else begin
            startup   <= {startup[0], 1'b1};
            regDstE   <= regDstD;
            aluSrcE   <= aluSrcD;
            aluOpE    <= aluOpD;
            memReadE  <= validD & memReadD;
            memWriteE <= validD & memWriteD;
            regWriteE <= validD & regWriteD;
            memToRegE <= memToRegD;
            memReadM  <= memReadE;
            memWriteM <= memWriteE;
            regWriteM <= regWriteE;
            memToRegM <= memToRegE;
            regWriteW <= regWriteM;
            memToRegW <= memToRegM;
        end
    end

    memExclusive: assert property (@(posedge clk) disable iff (reset) !(memReadM && memWriteM))
        else $error("Load and store both active in M");

endmodule

/* logic/regFile.sv */
`timescale 1ns/1ns

module regFile (
    input  logic             clk,
    input  logic             writeEn,
    input  mipsPkg::regIdx_t readAddrA,
    input  mipsPkg::regIdx_t readAddrB,
    input  mipsPkg::regIdx_t writeAddr,
    input  mipsPkg::word_t   writeData,
    output mipsPkg::word_t   readDataA,
    output mipsPkg::word_t   readDataB
);
    import mipsPkg::*;

    word_t regs [32];

    // Register 0 reads zero, a same-cycle write passes straight through
    function automatic word_t readPort(input regIdx_t addr);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (writeEn && addr == writeAddr) begin
            value = writeData;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_comb begin
        readDataA = readPort(readAddrA);
        readDataB = readPort(readAddrB);
    end

    always_ff @(posedge clk) begin
        if (writeEn && writeAddr != '0) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

/* logic/alu.sv */
`timescale 1ns/1ns

module alu (
    input  mipsPkg::word_t   srcA,
    input  mipsPkg::word_t   srcB,
    input  mipsPkg::regIdx_t shamt,
    input  mipsPkg::aluOp_t  op,
    output mipsPkg::word_t   result
);
    import mipsPkg::*;

    logic lessThan;

    // slt compares as signed
    assign lessThan = $signed(srcA) < $signed(srcB);

    always_comb begin
        case (op)
            aluAdd: begin
                result = srcA + srcB;
            end
            aluSub: begin
                result = srcA - srcB;
            end
            aluAnd: begin
                result = srcA & srcB;
            end
            aluOr: begin
                result = srcA | srcB;
            end
            aluSlt: begin
                result = {31'b0, lessThan};
            end
            aluSll: begin
                result = srcB << shamt;
            end
            // Immediate moved to the upper half
            aluLui: begin
                result = {srcB[15:0], 16'h0000};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* logic/datapath.sv */
`timescale 1ns/1ns

module datapath (
    input  logic             clk,
    input  logic             reset,
    input  mipsPkg::word_t   instr,
    input  mipsPkg::word_t   pcF,
    input  mipsPkg::word_t   memRdata,
    input  logic             signExt,
    input  logic             isBranch,
    input  logic             branchNe,
    input  logic             isLink,
    input  mipsPkg::regDst_t regDstE,
    input  logic             aluSrcE,
    input  mipsPkg::aluOp_t  aluOpE,
    input  logic             memReadM,
    input  logic             memWriteM,
    input  logic             regWriteW,
    input  logic             memToRegW,
    output logic             branchTaken,
    output mipsPkg::word_t   branchTarget,
    output mipsPkg::word_t   jumpTarget,
    output logic             memEn,
    output logic [3:0]       memWen,
    output mipsPkg::word_t   memAddr,
    output mipsPkg::word_t   memWdata
);
    import mipsPkg::*;

    // D stage
    word_t   pcD;
    word_t   pcPlus4D;
    word_t   pcPlus8D;
    regIdx_t rsD;
    regIdx_t rtD;
    regIdx_t rdD;
    regIdx_t shamtD;
    imm_t    immFieldD;
    word_t   immD;
    word_t   readDataA;
    word_t   readDataB;
    word_t   srcAD;
    word_t   srcBD;
    logic    equalD;
    // E stage
    word_t   srcAE;
    word_t   srcBE;
    word_t   immE;
    word_t   aluBE;
    word_t   aluOutE;
    regIdx_t rtE;
    regIdx_t rdE;
    regIdx_t shamtE;
    regIdx_t writeRegE;
    // M and W stages
    word_t   aluOutM;
    word_t   writeDataM;
    regIdx_t writeRegM;
    word_t   aluOutW;
    regIdx_t writeRegW;
    word_t   resultW;

    assign rsD       = instr[25:21];
    assign rtD       = instr[20:16];
    assign rdD       = instr[15:11];
    assign shamtD    = instr[10:6];
    assign immFieldD = instr[15:0];

    assign pcPlus4D = pcD + 32'd4;
    assign pcPlus8D = pcD + 32'd8;
    assign immD     = signExt ? {{16{immFieldD[15]}}, immFieldD} : {16'h0000, immFieldD};

    assign branchTarget = pcPlus4D + {immD[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4D[31:28], instr[25:0], 2'b00};

    regFile regs (
        .clk       (clk),
        .writeEn   (regWriteW),
        .readAddrA (rsD),
        .readAddrB (rtD),
        .writeAddr (writeRegW),
        .writeData (resultW),
        .readDataA (readDataA),
        .readDataB (readDataB)
    );

    // Branch resolved in D
    assign equalD      = readDataA == readDataB;
    assign branchTaken = isBranch & (equalD ^ branchNe);

    // jal goes through the ALU as PC+8 plus zero
    assign srcAD = isLink ? pcPlus8D : readDataA;
    assign srcBD = isLink ? '0 : readDataB;

    // Payload registers for every stage boundary
    always_ff @(posedge clk) begin
        pcD        <= pcF;
        srcAE      <= srcAD;
        srcBE      <= srcBD;
        immE       <= immD;
        rtE        <= rtD;
        rdE        <= rdD;
        shamtE     <= shamtD;
        aluOutM    <= aluOutE;
        writeDataM <= srcBE;
        writeRegM  <= writeRegE;
        aluOutW    <= aluOutM;
        writeRegW  <= writeRegM;
    end

    assign aluBE = aluSrcE ? immE : srcBE;

    always_comb begin
        case (regDstE)
            dstRd:   writeRegE = rdE;
            dstRt:   writeRegE = rtE;
            default: writeRegE = regRa;
        endcase
    end

    alu alu0 (
        .srcA   (srcAE),
        .srcB   (aluBE),
        .shamt  (shamtE),
        .op     (aluOpE),
        .result (aluOutE)
    );

    // Word accesses only
    assign memEn    = memReadM | memWriteM;
    assign memWen   = {4{memWriteM}};
    assign memAddr  = aluOutM;
    assign memWdata = writeDataM;

    assign resultW = memToRegW ? memRdata : aluOutW;

    memAligned: assert property (@(posedge clk) disable iff (reset) memEn |-> memAddr[1:0] == 2'b00)
        else $error("Unaligned data access at %h", memAddr);

endmodule

/* logic/mipsCore.sv */
`timescale 1ns/1ns

module mipsCore #(
    parameter mipsPkg::word_t resetPc = '0
) (
    input  logic           clk,
    input  logic           reset,
    input  mipsPkg::word_t instr,
    input  mipsPkg::word_t memRdata,
    output mipsPkg::word_t instAddr,
    output logic           instEn,
    output logic           memEn,
    output logic [3:0]     memWen,
    output mipsPkg::word_t memAddr,
    output mipsPkg::word_t memWdata
);
    import mipsPkg::*;

    word_t   pcF;
    word_t   branchTarget;
    word_t   jumpTarget;
    logic    branchTaken;
    logic    signExt;
    logic    isBranch;
    logic    branchNe;
    logic    isJump;
    logic    isLink;
    regDst_t regDstE;
    logic    aluSrcE;
    aluOp_t  aluOpE;
    logic    memReadM;
    logic    memWriteM;
    logic    regWriteW;
    logic    memToRegW;

    assign instAddr = pcF;

    pcUnit #(
        .resetPc (resetPc)
    ) pc0 (
        .clk          (clk),
        .reset        (reset),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .isJump       (isJump),
        .jumpTarget   (jumpTarget),
        .pcF          (pcF),
        .instEn       (instEn)
    );

    controlDecoder ctrl0 (
        .clk       (clk),
        .reset     (reset),
        .instr     (instr),
        .signExt   (signExt),
        .isBranch  (isBranch),
        .branchNe  (branchNe),
        .isJump    (isJump),
        .isLink    (isLink),
        .regDstE   (regDstE),
        .aluSrcE   (aluSrcE),
        .aluOpE    (aluOpE),
        .memReadM  (memReadM),
        .memWriteM (memWriteM),
        .regWriteW (regWriteW),
        .memToRegW (memToRegW)
    );

    datapath dp0 (
        .clk          (clk),
        .reset        (reset),
        .instr        (instr),
        .pcF          (pcF),
        .memRdata     (memRdata),
        .signExt      (signExt),
        .isBranch     (isBranch),
        .branchNe     (branchNe),
        .isLink       (isLink),
        .regDstE      (regDstE),
        .aluSrcE      (aluSrcE),
        .aluOpE       (aluOpE),
        .memReadM     (memReadM),
        .memWriteM    (memWriteM),
        .regWriteW    (regWriteW),
        .memToRegW    (memToRegW),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget),
        .jumpTarget   (jumpTarget),
        .memEn        (memEn),
        .memWen       (memWen),
        .memAddr      (memAddr),
        .memWdata     (memWdata)
    );

endmodule

/* tests/tbMemory.sv */
`timescale 1ns/1ns

module tbMemory (
    input  logic           clk,
    input  logic           instEn,
    input  mipsPkg::word_t instAddr,
    output mipsPkg::word_t instr,
    input  logic           memEn,
    input  logic [3:0]     memWen,
    input  mipsPkg::word_t memAddr,
    input  mipsPkg::word_t memWdata,
    output mipsPkg::word_t memRdata,
    output int             storeCount
);
    import mipsPkg::*;

    // 4 KB each, word indexed
    word_t rom [0:1023];
    word_t ram [0:1023];

    initial begin
        instr      = '0;
        memRdata   = '0;
        storeCount = 0;
    end

    // Instruction word lands in D one cycle after the fetch
    always @(posedge clk) begin
        if (instEn) begin
            instr <= rom[instAddr[11:2]];
        end
    end

    // Data port with one-cycle read and byte-enabled write
    always @(posedge clk) begin
        if (memEn) begin
            memRdata <= ram[memAddr[11:2]];
            for (int b = 0; b < 4; b++) begin
                if (memWen[b]) begin
                    ram[memAddr[11:2]][8*b +: 8] <= memWdata[8*b +: 8];
                end
            end
            if (memWen != 4'b0000) begin
                storeCount <= storeCount + 1;
            end
        end
    end

endmodule

/* tests/mipsCoreTb.sv */
`timescale 1ns/1ns

module mipsCoreTb;
    import mipsPkg::*;

    logic  clk;
    logic  reset;
    word_t instr;
    word_t memRdata;
    word_t instAddr;
    logic  instEn;
    logic  memEn;
    logic  [3:0] memWen;
    word_t memAddr;
    word_t memWdata;
    int    storeCount;

    // ISA model state used while assembling
    word_t model [32];
    word_t shadowRam [0:1023];
    word_t expAddr [64];
    word_t expData [64];
    int    expCount;
    int    progLen;
    int    storeOff;
    int    errors;
    int    seed;

    mipsCore #(.resetPc(32'h0)) dut (
        .clk(clk), .reset(reset), .instr(instr), .memRdata(memRdata),
        .instAddr(instAddr), .instEn(instEn), .memEn(memEn), .memWen(memWen),
        .memAddr(memAddr), .memWdata(memWdata)
    );

    tbMemory mem (
        .clk(clk), .instEn(instEn), .instAddr(instAddr), .instr(instr),
        .memEn(memEn), .memWen(memWen), .memAddr(memAddr), .memWdata(memWdata),
        .memRdata(memRdata), .storeCount(storeCount)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic word_t sext(input imm_t imm);
        return {{16{imm[15]}}, imm};
    endfunction

    task automatic setReg(input regIdx_t r, input word_t v);
        if (r != 5'd0) begin
            model[r] = v;
        end
    endtask

    task automatic emit(input word_t w);
        mem.rom[progLen[9:0]] = w;
        progLen++;
    endtask

    task automatic nops(input int n);
        for (int i = 0; i < n; i++) begin
            emit(32'h0);
        end
    endtask

    task automatic rOp(input funct_t fn, input regIdx_t rd, input regIdx_t rs,
                       input regIdx_t rt, input regIdx_t sh);
        word_t a;
        word_t b;
        word_t r;
        a = model[rs];
        b = model[rt];
        case (fn)
            fnAddu:  r = a + b;
            fnSubu:  r = a - b;
            fnAnd:   r = a & b;
            fnOr:    r = a | b;
            fnSlt:   r = {31'b0, $signed(a) < $signed(b)};
            default: r = b << sh;
        endcase
        emit({opSpecial, rs, rt, rd, sh, fn});
        setReg(rd, r);
    endtask

    task automatic iOp(input opcode_t op, input regIdx_t rt, input regIdx_t rs, input imm_t imm);
        word_t r;
        case (op)
            opAddiu: r = model[rs] + sext(imm);
            opAndi:  r = model[rs] & {16'h0000, imm};
            opOri:   r = model[rs] | {16'h0000, imm};
            default: r = {imm, 16'h0000};
        endcase
        emit({op, rs, rt, imm});
        setReg(rt, r);
    endtask

    task automatic loadWord(input regIdx_t rt, input regIdx_t base, input imm_t imm);
        word_t addr;
        addr = model[base] + sext(imm);
        emit({opLw, base, rt, imm});
        setReg(rt, shadowRam[addr[11:2]]);
    endtask

    // Stores off r13 at the next free offset; expected only if it should execute
    task automatic storeWord(input regIdx_t rt, input logic expected);
        word_t addr;
        addr = model[13] + word_t'(storeOff);
        emit({opSw, 5'd13, rt, storeOff[15:0]});
        storeOff += 4;
        if (expected) begin
            expAddr[expCount] = addr;
            expData[expCount] = model[rt];
            expCount++;
            shadowRam[addr[11:2]] = model[rt];
        end
    endtask

    // Branch over the fall-through slot, delay slot always runs
    task automatic branchCase(input opcode_t op, input regIdx_t rs, input regIdx_t rt);
        logic taken;
        taken = (model[rs] == model[rt]) ^ (op == opBne);
        emit({op, rs, rt, 16'd2});
        storeWord(rs, 1'b1);
        storeWord(rt, !taken);
    endtask

    task automatic jumpCase(input logic link);
        word_t here;
        word_t target;
        here = word_t'(progLen * 4);
        target = here + 32'd12;
        emit({link ? opJal : opJ, target[27:2]});
        if (link) begin
            setReg(regRa, here + 32'd8);
        end
        nops(1);
        storeWord(5'd1, 1'b0);
    endtask

    task automatic buildProgram();
        iOp(opAddiu, 5'd1, 5'd0, 16'h1234);
        iOp(opAddiu, 5'd2, 5'd0, 16'hFFFB);
        iOp(opLui, 5'd3, 5'd0, 16'hABCD);
        iOp(opOri, 5'd4, 5'd0, 16'h8001);
        iOp(opAddiu, 5'd13, 5'd0, 16'h0100);
        nops(3);
        rOp(fnAddu, 5'd5, 5'd1, 5'd2, 5'd0);
        rOp(fnSubu, 5'd6, 5'd1, 5'd2, 5'd0);
        rOp(fnAnd, 5'd7, 5'd3, 5'd2, 5'd0);
        rOp(fnOr, 5'd8, 5'd3, 5'd4, 5'd0);
        rOp(fnSlt, 5'd9, 5'd2, 5'd1, 5'd0);
        rOp(fnSlt, 5'd10, 5'd1, 5'd2, 5'd0);
        rOp(fnSll, 5'd11, 5'd0, 5'd1, 5'd4);
        iOp(opAndi, 5'd12, 5'd2, 16'hF0F0);
        nops(3);
        for (int r = 1; r <= 12; r++) begin
            storeWord(r[4:0], 1'b1);
        end
        branchCase(opBeq, 5'd1, 5'd1);
        branchCase(opBeq, 5'd1, 5'd2);
        branchCase(opBne, 5'd1, 5'd2);
        branchCase(opBne, 5'd2, 5'd2);
        // Register 0 ignores writes
        iOp(opAddiu, 5'd0, 5'd0, 16'h0055);
        nops(3);
        storeWord(5'd0, 1'b1);
        // Loads at positive and negative offsets
        iOp(opAddiu, 5'd15, 5'd0, 16'h0200);
        nops(3);
        loadWord(5'd16, 5'd15, 16'h000C);
        loadWord(5'd17, 5'd15, 16'hFFFC);
        nops(3);
        iOp(opAddiu, 5'd18, 5'd16, 16'h0007);
        rOp(fnAddu, 5'd19, 5'd17, 5'd16, 5'd0);
        nops(3);
        storeWord(5'd18, 1'b1);
        storeWord(5'd19, 1'b1);
        jumpCase(1'b0);
        jumpCase(1'b1);
        nops(3);
        storeWord(regRa, 1'b1);
        nops(4);
    endtask

    inReset: assert property (@(posedge clk) reset && $past(reset) |->
        (!memEn && memWen == 4'b0 && !instEn))
        else begin
            errors++;
            $display("FAIL %0t: memory or fetch enable active during reset", $time);
            $display("Result: FAILED");
            $fatal(1);
        end

    firstFetch: assert property (@(posedge clk) disable iff (reset)
        $rose(instEn) |-> instAddr == 32'h0)
        else begin
            errors++;
            $display("FAIL %0t: first fetch at %h instead of 0", $time, instAddr);
            $display("Result: FAILED");
            $fatal(1);
        end

    storeMatch: assert property (@(posedge clk) disable iff (reset)
        (memEn && memWen != 4'b0) |-> (storeCount < expCount && memAddr == expAddr[storeCount]
        && memWdata == expData[storeCount] && memWen == 4'b1111))
        else begin
            errors++;
            $display("FAIL %0t: store %0d wrote %h to %h, expected %h to %h", $time, storeCount,
                     memWdata, memAddr, expData[storeCount], expAddr[storeCount]);
            $display("Result: FAILED");
            $fatal(1);
        end

    // Upper address bits would otherwise alias into the 4 KB RAM
    dataInRam: assert property (@(posedge clk) disable iff (reset)
        memEn |-> memAddr[31:12] == '0)
        else begin
            errors++;
            $display("FAIL %0t: data access at %h lies outside the RAM", $time, memAddr);
            $display("Result: FAILED");
            $fatal(1);
        end

    // Watchdog scaled to the program length
    initial begin
        int timeoutNs;
        #1;
        timeoutNs = 40 * (progLen + 50);
        #(timeoutNs);
        $display("Timeout: only %0d of %0d expected stores arrived", storeCount, expCount);
        $display("Result: FAILED");
        $fatal(1);
    end

    initial begin
        seed = 24;
        reset = 1'b1;
        errors = 0;
        expCount = 0;
        progLen = 0;
        storeOff = 0;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end
        // Unused ROM words decode as nops
        for (int i = 0; i < 1024; i++) begin
            shadowRam[i[9:0]] = $random(seed);
            mem.ram[i[9:0]] = shadowRam[i[9:0]];
            mem.rom[i[9:0]] = '0;
        end
        buildProgram();
        repeat (3) @(posedge clk);
        #2 reset = 1'b0;
        wait (storeCount == expCount);
        // Extra cycles so a stray store still trips the check
        repeat (10) @(posedge clk);
        if (errors == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("Result: FAILED");
            $fatal(1);
        end
    end

endmodule

/* filelist.f */
logic/mipsPkg.sv
logic/pcUnit.sv
logic/controlDecoder.sv
logic/regFile.sv
logic/alu.sv
logic/datapath.sv
logic/mipsCore.sv
tests/tbMemory.sv
tests/mipsCoreTb.sv

/* Makefile */
# Verilator build and run of the MIPS core testbench

VERILATOR ?= verilator
TOP       ?= mipsCoreTb
FILELIST  ?= filelist.f
BUILD     ?= obj_dir
PASS_MSG  ?= Result: PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		--Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD)
